// ==== hdl/stream_pkg.sv ====
`default_nettype none

package stream_pkg;

  // Global run state, driven by the controller and watched by both streamers
  typedef enum logic [1:0] {
    ST_IDLE  = 2'd0,
    ST_RUN   = 2'd1,
    ST_DONE  = 2'd2,
    ST_ERROR = 2'd3
  } run_state_t;

  // Word at address 0. Writes carry commands, reads return status
  typedef union packed {
    struct packed {
      logic [29:0] reserved;
      logic        clear;
      logic        start;
    } ctrl;
    struct packed {
      logic [28:0] reserved;
      logic        error;
      logic        done;
      logic        busy;
    } stat;
  } csr_word_u;

  // Register map, byte addresses
  localparam logic [7:0] CSR_ADDR      = 8'h00;
  localparam logic [7:0] LEN_A_ADDR    = 8'h04;
  localparam logic [7:0] SWEEPS_A_ADDR = 8'h08;
  localparam logic [7:0] HOLD_A_ADDR   = 8'h0C;
  localparam logic [7:0] LEN_B_ADDR    = 8'h10;
  localparam logic [7:0] SWEEPS_B_ADDR = 8'h14;
  localparam logic [7:0] HOLD_B_ADDR   = 8'h18;

  // Operand memory windows
  localparam logic [11:0] MEM_A_BASE = 12'h100;
  localparam logic [11:0] MEM_B_BASE = 12'h200;

endpackage

`default_nettype wire

// ==== hdl/operand_bram.sv ====
`timescale 1ns/1ps
`default_nettype none

module operand_bram #(
  parameter int DATA_WIDTH     = 16,
  parameter int MEM_ADDR_WIDTH = 6
) (
  input  logic                      clk,
  input  logic                      we,
  input  logic [MEM_ADDR_WIDTH-1:0] wr_addr,
  input  logic [DATA_WIDTH-1:0]     wr_data,
  input  logic [MEM_ADDR_WIDTH-1:0] host_rd_addr,
  output logic [DATA_WIDTH-1:0]     host_rd_data,
  input  logic                      bram_en,
  input  logic [MEM_ADDR_WIDTH-1:0] bram_addr,
  output logic [DATA_WIDTH-1:0]     bram_rddata,
  output logic                      bram_rdack
);

  localparam int DEPTH = 2 ** MEM_ADDR_WIDTH;

  logic [DATA_WIDTH-1:0] mem [DEPTH];

  // Host side, write plus registered read for the bus
  always_ff @(posedge clk) begin
    if (we) begin
      mem[wr_addr] <= wr_data;
    end
    host_rd_data <= mem[host_rd_addr];
  end

  // Streamer side is read only, ack follows each enable by one cycle
  always_ff @(posedge clk) begin
    bram_rdack <= bram_en;
    if (bram_en) begin
      bram_rddata <= mem[bram_addr];
    end
  end

endmodule

`default_nettype wire

// ==== hdl/bram_streamer.sv ====
`timescale 1ns/1ps
`default_nettype none

module bram_streamer #(
  parameter int DATA_WIDTH     = 16,
  parameter int MEM_ADDR_WIDTH = 6,
  parameter int COUNT_WIDTH    = 16
) (
  input  logic                      clk,
  input  logic                      rst,
  input  stream_pkg::run_state_t    run_state,
  input  logic [COUNT_WIDTH-1:0]    len,
  input  logic [COUNT_WIDTH-1:0]    sweeps,
  input  logic [COUNT_WIDTH-1:0]    hold,
  output logic                      bram_en,
  output logic [MEM_ADDR_WIDTH-1:0] bram_addr,
  input  logic [DATA_WIDTH-1:0]     bram_rddata,
  input  logic                      bram_rdack,
  output logic [DATA_WIDTH-1:0]     tdata,
  output logic                      tvalid,
  input  logic                      tready,
  output logic                      tlast,
  output logic                      cfg_error
);

  import stream_pkg::*;

  // Local FSM states
  localparam logic [1:0] LOC_START   = 2'd0;
  localparam logic [1:0] LOC_OPERATE = 2'd1;
  localparam logic [1:0] LOC_END     = 2'd2;
  localparam logic [1:0] LOC_ERROR   = 2'd3;

  logic [1:0]             loc_state;
  logic [COUNT_WIDTH-1:0] addr_cnt;
  logic [COUNT_WIDTH-1:0] sweep_cnt;
  logic [COUNT_WIDTH-1:0] hold_cnt;
  logic                   rd_tag;

  // Two-entry buffer, entry 0 is the head
  logic [DATA_WIDTH-1:0]  buf_data [2];
  logic [1:0]             buf_last;
  logic [1:0]             buf_cnt;
  logic                   wr_slot;
  logic [2:0]             level;

  logic in_run;
  logic streaming;
  logic addr_wrap;
  logic final_read;
  logic final_hold;
  logic beat;
  logic push;
  logic pop;

  assign in_run     = (run_state == ST_RUN);
  assign streaming  = (loc_state == LOC_OPERATE) || (loc_state == LOC_END);
  assign addr_wrap  = (addr_cnt == len - 1'b1);
  assign final_read = addr_wrap && (sweep_cnt == sweeps - 1'b1);
  assign cfg_error  = (loc_state == LOC_ERROR);

  // Entries held after this edge, counting the read landing now
  assign level     = {1'b0, buf_cnt} + {2'b00, bram_rdack} - {2'b00, pop};
  assign bram_en   = (loc_state == LOC_OPERATE) && in_run && (level < 3'd2);
  assign bram_addr = addr_cnt[MEM_ADDR_WIDTH-1:0];

  // Output side, head word repeated for hold beats
  assign tvalid     = streaming && (buf_cnt != 2'd0);
  assign tdata      = buf_data[0];
  assign final_hold = (hold_cnt == hold - 1'b1);
  assign tlast      = buf_last[0] && final_hold;
  assign beat       = tvalid && tready;
  assign pop        = beat && final_hold;
  assign push       = streaming && bram_rdack;

  // Slot for the incoming word once the head has moved on
  assign wr_slot = buf_cnt[1] || (buf_cnt[0] && !pop);

  always_ff @(posedge clk) begin
    if (rst) begin
      loc_state <= LOC_START;
      addr_cnt  <= '0;
      sweep_cnt <= '0;
      rd_tag    <= 1'b0;
    end else begin
      // Tag travels alongside the read for one cycle
      rd_tag <= bram_en && final_read;
      case (loc_state)
        LOC_START: begin
          addr_cnt  <= '0;
          sweep_cnt <= '0;
          if (in_run) begin
            if (len == '0 || sweeps == '0 || hold == '0) begin
              loc_state <= LOC_ERROR;
            end else begin
              loc_state <= LOC_OPERATE;
            end
          end
        end
        LOC_OPERATE: begin
          if (!in_run) begin
            loc_state <= LOC_START;
          end else if (bram_en) begin
            if (addr_wrap) begin
              addr_cnt  <= '0;
              sweep_cnt <= sweep_cnt + 1'b1;
              if (final_read) begin
                loc_state <= LOC_END;
              end
            end else begin
              addr_cnt <= addr_cnt + 1'b1;
            end
          end
        end
        default: begin
          // End and error wait for the controller to leave run
          if (!in_run) begin
            loc_state <= LOC_START;
          end
        end
      endcase
    end
  end

  // Occupancy and hold count, flushed whenever not streaming
  always_ff @(posedge clk) begin
    if (rst || !streaming) begin
      buf_cnt  <= '0;
      hold_cnt <= '0;
    end else begin
      buf_cnt <= buf_cnt + {1'b0, push} - {1'b0, pop};
      if (beat) begin
        hold_cnt <= final_hold ? '0 : hold_cnt + 1'b1;
      end
    end
  end

  always_ff @(posedge clk) begin
    if (pop) begin
      buf_data[0] <= buf_data[1];
      buf_last[0] <= buf_last[1];
    end
    if (push) begin
      buf_data[wr_slot] <= bram_rddata;
      buf_last[wr_slot] <= rd_tag;
    end
  end

  // A stalled beat keeps its payload, unless the run is aborted
  a_stall_stable: assert property (@(posedge clk) disable iff (rst)
    tvalid && !tready |=> !tvalid || ($stable(tdata) && $stable(tlast)));

endmodule

`default_nettype wire

// ==== hdl/pair_combiner.sv ====
`timescale 1ns/1ps
`default_nettype none

module pair_combiner #(
  parameter int DATA_WIDTH = 16
) (
  input  logic                      clk,
  input  logic                      rst,
  input  logic [DATA_WIDTH-1:0]     a_tdata,
  input  logic                      a_tvalid,
  output logic                      a_tready,
  input  logic                      a_tlast,
  input  logic [DATA_WIDTH-1:0]     b_tdata,
  input  logic                      b_tvalid,
  output logic                      b_tready,
  input  logic                      b_tlast,
  output logic [2*DATA_WIDTH-1:0]   out_tdata,
  output logic                      out_tvalid,
  input  logic                      out_tready,
  output logic                      out_tlast,
  output logic                      align_error,
  output logic                      last_sent
);

  localparam int PROD_WIDTH = 2 * DATA_WIDTH;

  logic slot_free;
  logic join_pair;
  logic mismatch;
  logic load;

  // Output slot is free when empty or emptying this cycle
  assign slot_free = !out_tvalid || out_tready;
  assign join_pair = a_tvalid && b_tvalid && slot_free && !align_error;
  assign mismatch  = join_pair && (a_tlast != b_tlast);
  assign load      = join_pair && !mismatch;

  // Both sides are taken together or not at all
  assign a_tready = join_pair;
  assign b_tready = join_pair;

  assign last_sent = out_tvalid && out_tready && out_tlast;

  always_ff @(posedge clk) begin
    if (rst) begin
      out_tvalid  <= 1'b0;
      align_error <= 1'b0;
    end else begin
      // Sticky, a misaligned pair is dropped and the output stays quiet
      if (mismatch) begin
        align_error <= 1'b1;
      end
      if (load) begin
        out_tvalid <= 1'b1;
      end else if (out_tready) begin
        out_tvalid <= 1'b0;
      end
    end
  end

  always_ff @(posedge clk) begin
    if (load) begin
      out_tdata <= PROD_WIDTH'(a_tdata) * PROD_WIDTH'(b_tdata);
      out_tlast <= a_tlast && b_tlast;
    end
  end

  a_quiet_after_align: assert property (@(posedge clk) disable iff (rst)
    align_error |-> !$rose(out_tvalid));

endmodule

`default_nettype wire

// ==== hdl/run_controller.sv ====
`timescale 1ns/1ps
`default_nettype none

module run_controller #(
  parameter int DATA_WIDTH     = 16,
  parameter int MEM_ADDR_WIDTH = 6,
  parameter int COUNT_WIDTH    = 16
) (
  input  logic                      clk,
  input  logic                      rst,
  input  logic                      wb_cyc,
  input  logic                      wb_stb,
  input  logic                      wb_we,
  input  logic [11:0]               wb_adr,
  input  logic [31:0]               wb_dat_w,
  output logic [31:0]               wb_dat_r,
  output logic                      wb_ack,
  output stream_pkg::run_state_t    run_state,
  input  logic                      cfg_error_a,
  input  logic                      cfg_error_b,
  input  logic                      align_error,
  input  logic                      last_sent,
  output logic                      mem_a_we,
  output logic                      mem_b_we,
  output logic [MEM_ADDR_WIDTH-1:0] mem_wr_addr,
  output logic [DATA_WIDTH-1:0]     mem_wr_data,
  output logic [MEM_ADDR_WIDTH-1:0] mem_rd_addr,
  input  logic [DATA_WIDTH-1:0]     mem_a_rdata,
  input  logic [DATA_WIDTH-1:0]     mem_b_rdata,
  output logic [COUNT_WIDTH-1:0]    len_a,
  output logic [COUNT_WIDTH-1:0]    sweeps_a,
  output logic [COUNT_WIDTH-1:0]    hold_a,
  output logic [COUNT_WIDTH-1:0]    len_b,
  output logic [COUNT_WIDTH-1:0]    sweeps_b,
  output logic [COUNT_WIDTH-1:0]    hold_b
);

  import stream_pkg::*;

  // Byte span of one memory window
  localparam logic [11:0] WIN_MASK = 12'((1 << (MEM_ADDR_WIDTH + 2)) - 1);

  logic      reg_sel;
  logic      win_a;
  logic      win_b;
  logic      wr_cycle;
  logic      cfg_open;
  logic      csr_wr;
  csr_word_u cmd;
  csr_word_u status;

  assign reg_sel = (wb_adr[11:8] == 4'h0);
  assign win_a   = ((wb_adr & ~WIN_MASK) == MEM_A_BASE);
  assign win_b   = ((wb_adr & ~WIN_MASK) == MEM_B_BASE);

  // Writes take effect in the ack cycle, so start shows up one cycle later
  assign wr_cycle = wb_cyc && wb_stb && wb_we && wb_ack;
  assign cfg_open = (run_state != ST_RUN);
  assign csr_wr   = wr_cycle && reg_sel && (wb_adr[7:0] == CSR_ADDR);
  assign cmd      = wb_dat_w;

  assign mem_wr_addr = wb_adr[MEM_ADDR_WIDTH+1:2];
  assign mem_rd_addr = wb_adr[MEM_ADDR_WIDTH+1:2];
  assign mem_wr_data = wb_dat_w[DATA_WIDTH-1:0];
  assign mem_a_we    = wr_cycle && cfg_open && win_a;
  assign mem_b_we    = wr_cycle && cfg_open && win_b;

  // One idle cycle before ack covers the registered memory read
  always_ff @(posedge clk) begin
    if (rst) begin
      wb_ack <= 1'b0;
    end else begin
      wb_ack <= wb_cyc && wb_stb && !wb_ack;
    end
  end

  always_ff @(posedge clk) begin
    if (rst) begin
      len_a    <= '0;
      sweeps_a <= '0;
      hold_a   <= '0;
      len_b    <= '0;
      sweeps_b <= '0;
      hold_b   <= '0;
    end else if (wr_cycle && cfg_open && reg_sel) begin
      case (wb_adr[7:0])
        LEN_A_ADDR:    len_a    <= wb_dat_w[COUNT_WIDTH-1:0];
        SWEEPS_A_ADDR: sweeps_a <= wb_dat_w[COUNT_WIDTH-1:0];
        HOLD_A_ADDR:   hold_a   <= wb_dat_w[COUNT_WIDTH-1:0];
        LEN_B_ADDR:    len_b    <= wb_dat_w[COUNT_WIDTH-1:0];
        SWEEPS_B_ADDR: sweeps_b <= wb_dat_w[COUNT_WIDTH-1:0];
        HOLD_B_ADDR:   hold_b   <= wb_dat_w[COUNT_WIDTH-1:0];
        default: begin
        end
      endcase
    end
  end

  // Global run FSM
  always_ff @(posedge clk) begin
    if (rst) begin
      run_state <= ST_IDLE;
    end else begin
      case (run_state)
        ST_IDLE: begin
          if (csr_wr && cmd.ctrl.start) begin
            run_state <= ST_RUN;
          end
        end
        ST_RUN: begin
          // Errors win over a final beat seen in the same cycle
          if (cfg_error_a || cfg_error_b || align_error) begin
            run_state <= ST_ERROR;
          end else if (last_sent) begin
            run_state <= ST_DONE;
          end
        end
        default: begin
          if (csr_wr && cmd.ctrl.clear) begin
            run_state <= ST_IDLE;
          end
        end
      endcase
    end
  end

  always_comb begin
    status            = '0;
    status.stat.busy  = (run_state == ST_RUN);
    status.stat.done  = (run_state == ST_DONE);
    status.stat.error = (run_state == ST_ERROR);
  end

  always_comb begin
    wb_dat_r = '0;
    if (win_a) begin
      wb_dat_r = 32'(mem_a_rdata);
    end else if (win_b) begin
      wb_dat_r = 32'(mem_b_rdata);
    end else if (reg_sel) begin
      case (wb_adr[7:0])
        CSR_ADDR:      wb_dat_r = status;
        LEN_A_ADDR:    wb_dat_r = 32'(len_a);
        SWEEPS_A_ADDR: wb_dat_r = 32'(sweeps_a);
        HOLD_A_ADDR:   wb_dat_r = 32'(hold_a);
        LEN_B_ADDR:    wb_dat_r = 32'(len_b);
        SWEEPS_B_ADDR: wb_dat_r = 32'(sweeps_b);
        HOLD_B_ADDR:   wb_dat_r = 32'(hold_b);
        default:       wb_dat_r = '0;
      endcase
    end
  end

  a_ack_in_cycle: assert property (@(posedge clk) disable iff (rst)
    wb_ack |-> wb_cyc && wb_stb);

endmodule

`default_nettype wire

// ==== hdl/operand_streamer_top.sv ====
`timescale 1ns/1ps
`default_nettype none

module operand_streamer_top #(
  parameter int DATA_WIDTH     = 16,
  parameter int MEM_ADDR_WIDTH = 6,
  parameter int COUNT_WIDTH    = 16
) (
  input  logic                    clk,
  input  logic                    rst,
  input  logic                    wb_cyc,
  input  logic                    wb_stb,
  input  logic                    wb_we,
  input  logic [11:0]             wb_adr,
  input  logic [31:0]             wb_dat_w,
  output logic [31:0]             wb_dat_r,
  output logic                    wb_ack,
  output logic [2*DATA_WIDTH-1:0] out_tdata,
  output logic                    out_tvalid,
  input  logic                    out_tready,
  output logic                    out_tlast
);

  import stream_pkg::*;

  run_state_t run_state;

  // Host side of the memories
  logic                      mem_a_we;
  logic                      mem_b_we;
  logic [MEM_ADDR_WIDTH-1:0] mem_wr_addr;
  logic [MEM_ADDR_WIDTH-1:0] mem_rd_addr;
  logic [DATA_WIDTH-1:0]     mem_wr_data;
  logic [DATA_WIDTH-1:0]     mem_a_rdata;
  logic [DATA_WIDTH-1:0]     mem_b_rdata;

  // Sweep settings
  logic [COUNT_WIDTH-1:0] len_a;
  logic [COUNT_WIDTH-1:0] sweeps_a;
  logic [COUNT_WIDTH-1:0] hold_a;
  logic [COUNT_WIDTH-1:0] len_b;
  logic [COUNT_WIDTH-1:0] sweeps_b;
  logic [COUNT_WIDTH-1:0] hold_b;

  // Streamer read ports
  logic                      bram_en_a;
  logic                      bram_en_b;
  logic [MEM_ADDR_WIDTH-1:0] bram_addr_a;
  logic [MEM_ADDR_WIDTH-1:0] bram_addr_b;
  logic [DATA_WIDTH-1:0]     bram_rddata_a;
  logic [DATA_WIDTH-1:0]     bram_rddata_b;
  logic                      bram_rdack_a;
  logic                      bram_rdack_b;

  // Operand streams and status
  logic [DATA_WIDTH-1:0] a_tdata;
  logic [DATA_WIDTH-1:0] b_tdata;
  logic                  a_tvalid;
  logic                  b_tvalid;
  logic                  a_tready;
  logic                  b_tready;
  logic                  a_tlast;
  logic                  b_tlast;
  logic                  cfg_error_a;
  logic                  cfg_error_b;
  logic                  align_error;
  logic                  last_sent;

  run_controller #(
    .DATA_WIDTH     (DATA_WIDTH),
    .MEM_ADDR_WIDTH (MEM_ADDR_WIDTH),
    .COUNT_WIDTH    (COUNT_WIDTH)
  ) u_ctrl (
    .clk         (clk),
    .rst         (rst),
    .wb_cyc      (wb_cyc),
    .wb_stb      (wb_stb),
    .wb_we       (wb_we),
    .wb_adr      (wb_adr),
    .wb_dat_w    (wb_dat_w),
    .wb_dat_r    (wb_dat_r),
    .wb_ack      (wb_ack),
    .run_state   (run_state),
    .cfg_error_a (cfg_error_a),
    .cfg_error_b (cfg_error_b),
    .align_error (align_error),
    .last_sent   (last_sent),
    .mem_a_we    (mem_a_we),
    .mem_b_we    (mem_b_we),
    .mem_wr_addr (mem_wr_addr),
    .mem_wr_data (mem_wr_data),
    .mem_rd_addr (mem_rd_addr),
    .mem_a_rdata (mem_a_rdata),
    .mem_b_rdata (mem_b_rdata),
    .len_a       (len_a),
    .sweeps_a    (sweeps_a),
    .hold_a      (hold_a),
    .len_b       (len_b),
    .sweeps_b    (sweeps_b),
    .hold_b      (hold_b)
  );

  operand_bram #(
    .DATA_WIDTH     (DATA_WIDTH),
    .MEM_ADDR_WIDTH (MEM_ADDR_WIDTH)
  ) u_mem_a (
    .clk          (clk),
    .we           (mem_a_we),
    .wr_addr      (mem_wr_addr),
    .wr_data      (mem_wr_data),
    .host_rd_addr (mem_rd_addr),
    .host_rd_data (mem_a_rdata),
    .bram_en      (bram_en_a),
    .bram_addr    (bram_addr_a),
    .bram_rddata  (bram_rddata_a),
    .bram_rdack   (bram_rdack_a)
  );

  operand_bram #(
    .DATA_WIDTH     (DATA_WIDTH),
    .MEM_ADDR_WIDTH (MEM_ADDR_WIDTH)
  ) u_mem_b (
    .clk          (clk),
    .we           (mem_b_we),
    .wr_addr      (mem_wr_addr),
    .wr_data      (mem_wr_data),
    .host_rd_addr (mem_rd_addr),
    .host_rd_data (mem_b_rdata),
    .bram_en      (bram_en_b),
    .bram_addr    (bram_addr_b),
    .bram_rddata  (bram_rddata_b),
    .bram_rdack   (bram_rdack_b)
  );

  bram_streamer #(
    .DATA_WIDTH     (DATA_WIDTH),
    .MEM_ADDR_WIDTH (MEM_ADDR_WIDTH),
    .COUNT_WIDTH    (COUNT_WIDTH)
  ) u_stream_a (
    .clk         (clk),
    .rst         (rst),
    .run_state   (run_state),
    .len         (len_a),
    .sweeps      (sweeps_a),
    .hold        (hold_a),
    .bram_en     (bram_en_a),
    .bram_addr   (bram_addr_a),
    .bram_rddata (bram_rddata_a),
    .bram_rdack  (bram_rdack_a),
    .tdata       (a_tdata),
    .tvalid      (a_tvalid),
    .tready      (a_tready),
    .tlast       (a_tlast),
    .cfg_error   (cfg_error_a)
  );

  bram_streamer #(
    .DATA_WIDTH     (DATA_WIDTH),
    .MEM_ADDR_WIDTH (MEM_ADDR_WIDTH),
    .COUNT_WIDTH    (COUNT_WIDTH)
  ) u_stream_b (
    .clk         (clk),
    .rst         (rst),
    .run_state   (run_state),
    .len         (len_b),
    .sweeps      (sweeps_b),
    .hold        (hold_b),
    .bram_en     (bram_en_b),
    .bram_addr   (bram_addr_b),
    .bram_rddata (bram_rddata_b),
    .bram_rdack  (bram_rdack_b),
    .tdata       (b_tdata),
    .tvalid      (b_tvalid),
    .tready      (b_tready),
    .tlast       (b_tlast),
    .cfg_error   (cfg_error_b)
  );

  pair_combiner #(
    .DATA_WIDTH (DATA_WIDTH)
  ) u_combiner (
    .clk         (clk),
    .rst         (rst),
    .a_tdata     (a_tdata),
    .a_tvalid    (a_tvalid),
    .a_tready    (a_tready),
    .a_tlast     (a_tlast),
    .b_tdata     (b_tdata),
    .b_tvalid    (b_tvalid),
    .b_tready    (b_tready),
    .b_tlast     (b_tlast),
    .out_tdata   (out_tdata),
    .out_tvalid  (out_tvalid),
    .out_tready  (out_tready),
    .out_tlast   (out_tlast),
    .align_error (align_error),
    .last_sent   (last_sent)
  );

endmodule

`default_nettype wire

// ==== sim/tb_operand_streamer.sv ====
`timescale 1ns/1ps
`default_nettype none

module tb_operand_streamer;

  import stream_pkg::*;

  localparam int DATA_WIDTH  = 16;
  localparam int PROD_WIDTH  = 2 * DATA_WIDTH;
  localparam int IMG_WORDS   = 12;
  // Output beats of all runs including the error runs
  localparam int TOTAL_BEATS = 4 + 12 + 4 + 4 + 6;
  localparam int CYCLE_LIMIT = 4 * TOTAL_BEATS + 2000;

  logic                  clk;
  logic                  rst;
  logic                  wb_cyc;
  logic                  wb_stb;
  logic                  wb_we;
  logic [11:0]           wb_adr;
  logic [31:0]           wb_dat_w;
  logic [31:0]           wb_dat_r;
  logic                  wb_ack;
  logic [PROD_WIDTH-1:0] out_tdata;
  logic                  out_tvalid;
  logic                  out_tready;
  logic                  out_tlast;

  logic [31:0]           lfsr_state;
  logic [DATA_WIDTH-1:0] img_a [IMG_WORDS];
  logic [DATA_WIDTH-1:0] img_b [IMG_WORDS];
  logic [7:0]            reg_addr [6];
  logic                  ready_random;
  logic                  rand_ready;
  logic [31:0]           ready_bits;
  logic [31:0]           rnd;
  logic [31:0]           rdata;
  logic [31:0]           wval;
  csr_word_u             status_exp;

  // Settings of the run in flight for the reference model
  int cur_len_a;
  int cur_hold_a;
  int cur_len_b;
  int cur_hold_b;
  int tot_a;
  int tot_b;
  int beat_limit;
  int beat_cnt;
  int cycle_cnt;

  operand_streamer_top #(
    .DATA_WIDTH     (DATA_WIDTH),
    .MEM_ADDR_WIDTH (6),
    .COUNT_WIDTH    (16)
  ) u_dut (
    .clk        (clk),
    .rst        (rst),
    .wb_cyc     (wb_cyc),
    .wb_stb     (wb_stb),
    .wb_we      (wb_we),
    .wb_adr     (wb_adr),
    .wb_dat_w   (wb_dat_w),
    .wb_dat_r   (wb_dat_r),
    .wb_ack     (wb_ack),
    .out_tdata  (out_tdata),
    .out_tvalid (out_tvalid),
    .out_tready (out_tready),
    .out_tlast  (out_tlast)
  );

  always #5 clk = ~clk;

  function automatic logic [31:0] lfsr_step(input logic [31:0] s);
    return s[0] ? ((s >> 1) ^ 32'h8020_0003) : (s >> 1);
  endfunction

  // One LFSR step per bit with the newest bit at the bottom
  task automatic take_bits(input int n, output logic [31:0] v);
    v = '0;
    for (int i = 0; i < n; i++) begin
      v = {v[30:0], lfsr_state[0]};
      lfsr_state = lfsr_step(lfsr_state);
    end
  endtask

  // Operand index per side is beat / hold wrapped at the sweep length
  function automatic logic [PROD_WIDTH-1:0] expected_product(input int k, input int la,
                                                             input int ha, input int lb,
                                                             input int hb);
    int ia;
    int ib;
    ia = (k / ha) % la;
    ib = (k / hb) % lb;
    return PROD_WIDTH'(img_a[ia]) * PROD_WIDTH'(img_b[ib]);
  endfunction

  task automatic report_failure(input string msg);
    $display("%s", msg);
    $display("ERRORS FOUND");
    $fatal(1);
  endtask

  task automatic check_product(input logic [PROD_WIDTH-1:0] exp,
                               input logic [PROD_WIDTH-1:0] got, input int k);
    if (got !== exp) begin
      report_failure($sformatf("Mismatch out_tdata beat %0d expected 0x%08h got 0x%08h",
                               k, exp, got));
    end
  endtask

  task automatic check_last(input logic exp, input logic got, input int k);
    if (got !== exp) begin
      report_failure($sformatf("Mismatch out_tlast beat %0d expected 0x%0h got 0x%0h",
                               k, exp, got));
    end
  endtask

  task automatic check_status(input csr_word_u exp, input csr_word_u got);
    if (got !== exp) begin
      report_failure($sformatf("Mismatch status expected 0x%08h got 0x%08h", exp, got));
    end
  endtask

  task automatic check_readback(input logic [11:0] adr, input logic [31:0] exp,
                                input logic [31:0] got);
    if (got !== exp) begin
      report_failure($sformatf("Mismatch wb_dat_r at 0x%03h expected 0x%08h got 0x%08h",
                               adr, exp, got));
    end
  endtask

  // Single classic cycle with inputs moving 1 ns after the edge
  task automatic wb_cycle(input logic we, input logic [11:0] adr, input logic [31:0] wdata,
                          output logic [31:0] rd);
    @(posedge clk);
    #1;
    wb_cyc   = 1'b1;
    wb_stb   = 1'b1;
    wb_we    = we;
    wb_adr   = adr;
    wb_dat_w = wdata;
    @(negedge clk);
    while (!wb_ack) begin
      @(negedge clk);
    end
    rd = wb_dat_r;
    @(posedge clk);
    #1;
    wb_cyc = 1'b0;
    wb_stb = 1'b0;
    wb_we  = 1'b0;
  endtask

  task automatic wb_write(input logic [11:0] adr, input logic [31:0] wdata);
    logic [31:0] unused;
    wb_cycle(1'b1, adr, wdata, unused);
  endtask

  task automatic wb_read(input logic [11:0] adr, output logic [31:0] rd);
    wb_cycle(1'b0, adr, 32'h0, rd);
  endtask

  // Program both sides and start the run and clear it once it has ended
  task automatic run_case(input int la, input int sa, input int ha, input int lb,
                          input int sb, input int hb, input logic expect_error);
    csr_word_u   cmd;
    csr_word_u   st;
    csr_word_u   exp;
    logic [31:0] d;
    cur_len_a  = la;
    cur_hold_a = ha;
    cur_len_b  = lb;
    cur_hold_b = hb;
    tot_a      = la * sa * ha;
    tot_b      = lb * sb * hb;
    beat_limit = (tot_a < tot_b) ? tot_a : tot_b;
    beat_cnt   = 0;
    wb_write({4'h0, LEN_A_ADDR}, 32'(la));
    wb_write({4'h0, SWEEPS_A_ADDR}, 32'(sa));
    wb_write({4'h0, HOLD_A_ADDR}, 32'(ha));
    wb_write({4'h0, LEN_B_ADDR}, 32'(lb));
    wb_write({4'h0, SWEEPS_B_ADDR}, 32'(sb));
    wb_write({4'h0, HOLD_B_ADDR}, 32'(hb));
    cmd = '0;
    cmd.ctrl.start = 1'b1;
    wb_write({4'h0, CSR_ADDR}, cmd);
    do begin
      wb_read({4'h0, CSR_ADDR}, d);
      st = d;
    end while (st.stat.busy);
    exp = '0;
    if (expect_error) begin
      exp.stat.error = 1'b1;
    end else begin
      exp.stat.done = 1'b1;
    end
    check_status(exp, st);
    if (!expect_error && beat_cnt != beat_limit) begin
      report_failure($sformatf("Run ended after %0d product beats instead of %0d",
                               beat_cnt, beat_limit));
    end
    cmd = '0;
    cmd.ctrl.clear = 1'b1;
    wb_write({4'h0, CSR_ADDR}, cmd);
    wb_read({4'h0, CSR_ADDR}, d);
    exp = '0;
    check_status(exp, d);
  endtask

  // Back-pressure is random only while enabled
  always @(posedge clk) begin
    rand_ready = ready_random;
    #1;
    if (rand_ready) begin
      take_bits(1, ready_bits);
      out_tready = ready_bits[0];
    end else begin
      out_tready = 1'b1;
    end
  end

  // Output monitor samples mid-cycle where valid and ready are settled
  always @(negedge clk) begin
    if (!rst && out_tvalid && out_tready) begin
      if (beat_cnt >= beat_limit) begin
        report_failure($sformatf("Product beat %0d appeared, but at most %0d were allowed",
                                 beat_cnt, beat_limit));
      end
      check_product(expected_product(beat_cnt, cur_len_a, cur_hold_a, cur_len_b, cur_hold_b),
                    out_tdata, beat_cnt);
      check_last((beat_cnt == tot_a - 1) && (beat_cnt == tot_b - 1), out_tlast, beat_cnt);
      beat_cnt = beat_cnt + 1;
    end
  end

  always @(posedge clk) begin
    cycle_cnt <= cycle_cnt + 1;
    if (cycle_cnt >= CYCLE_LIMIT) begin
      report_failure($sformatf("Timeout: the tests did not finish within %0d cycles",
                               CYCLE_LIMIT));
    end
  end

  initial begin
    clk          = 1'b0;
    rst          = 1'b1;
    wb_cyc       = 1'b0;
    wb_stb       = 1'b0;
    wb_we        = 1'b0;
    wb_adr       = '0;
    wb_dat_w     = '0;
    out_tready   = 1'b1;
    ready_random = 1'b0;
    lfsr_state   = 32'h3d1b_8bdb;
    cycle_cnt    = 0;
    beat_cnt     = 0;
    beat_limit   = 0;
    tot_a        = 0;
    tot_b        = 0;
    cur_len_a    = 1;
    cur_hold_a   = 1;
    cur_len_b    = 1;
    cur_hold_b   = 1;
    reg_addr     = '{LEN_A_ADDR, SWEEPS_A_ADDR, HOLD_A_ADDR,
                     LEN_B_ADDR, SWEEPS_B_ADDR, HOLD_B_ADDR};
    repeat (3) @(posedge clk);
    #1;
    rst = 1'b0;

    // Idle after reset
    wb_read({4'h0, CSR_ADDR}, rdata);
    status_exp = '0;
    check_status(status_exp, rdata);

    // Register and memory readback
    for (int i = 0; i < 6; i++) begin
      wval = {16'h0, 16'h1a00 + 16'(i) * 16'h0111};
      wb_write({4'h0, reg_addr[i]}, wval);
      wb_read({4'h0, reg_addr[i]}, rdata);
      check_readback({4'h0, reg_addr[i]}, wval, rdata);
    end
    for (int i = 0; i < IMG_WORDS; i++) begin
      take_bits(DATA_WIDTH, rnd);
      img_a[i] = rnd[DATA_WIDTH-1:0];
      take_bits(DATA_WIDTH, rnd);
      img_b[i] = rnd[DATA_WIDTH-1:0];
      wb_write(MEM_A_BASE + 12'(4 * i), {16'h0, img_a[i]});
      wb_write(MEM_B_BASE + 12'(4 * i), {16'h0, img_b[i]});
    end
    for (int i = 0; i < IMG_WORDS; i++) begin
      wb_read(MEM_A_BASE + 12'(4 * i), rdata);
      check_readback(MEM_A_BASE + 12'(4 * i), {16'h0, img_a[i]}, rdata);
      wb_read(MEM_B_BASE + 12'(4 * i), rdata);
      check_readback(MEM_B_BASE + 12'(4 * i), {16'h0, img_b[i]}, rdata);
    end

    // Plain run with ready held high
    run_case(4, 1, 1, 4, 1, 1, 1'b0);

    // Mixed sweeps and hold under back-pressure
    ready_random = 1'b1;
    run_case(2, 3, 2, 12, 1, 1, 1'b0);
    ready_random = 1'b0;

    // Zero length on A followed by a clean run
    run_case(0, 1, 1, 4, 1, 1, 1'b1);
    run_case(4, 1, 1, 4, 1, 1, 1'b0);

    // Misaligned last keeps the combiner quiet from here on
    run_case(4, 1, 1, 6, 1, 1, 1'b1);

    $display("NO ERRORS");
    $finish;
  end

endmodule

`default_nettype wire

// ==== filelist.f ====
hdl/stream_pkg.sv
hdl/operand_bram.sv
hdl/bram_streamer.sv
hdl/pair_combiner.sv
hdl/run_controller.sv
hdl/operand_streamer_top.sv
sim/tb_operand_streamer.sv
